// File: design/dsp_core_pkg.sv
package dsp_core_pkg;

    // Memory and counter sizes
    localparam int PM_AW  = 8;  // Program memory, 256 words
    localparam int DM_AW  = 8;  // Data RAM, 256 words
    localparam int PC_W   = 12;
    localparam int APB_AW = 12;

    // Host address map, byte addresses with a 4-byte stride
    localparam logic [APB_AW-1:0] ADDR_PM_BASE  = 12'h000;
    localparam logic [APB_AW-1:0] ADDR_CTRL     = 12'h400;
    localparam logic [APB_AW-1:0] ADDR_STATUS   = 12'h404;
    localparam logic [APB_AW-1:0] ADDR_REG_BASE = 12'h410;
    localparam logic [APB_AW-1:0] ADDR_DM_BASE  = 12'h800;

    // T field, instruction bits 15:11
    typedef enum logic [4:0] {
        OP_GOTO      = 5'b00000,
        OP_CALL      = 5'b10000,
        OP_RET       = 5'b11000,
        OP_SHORT_IMM = 5'b00010,
        OP_LONG_IMM  = 5'b01010,
        OP_LOAD_Y    = 5'b01111,
        OP_STORE_Y   = 5'b01100
    } opcode_e;

    // YAAU registers in register field order
    typedef enum logic [2:0] {
        R0, R1, R2, R3,
        RJ, RK, RB, RE
    } yreg_e;

    // Pointer post-modify, bits 1:0 of a RAM access
    typedef enum logic [1:0] {
        PM_NONE,   // *rN
        PM_INC,    // *rN++
        PM_DEC,    // *rN--
        PM_INC_J   // *rN++j
    } post_mod_e;

    // Decoded control word
    typedef struct packed {
        logic            jump;
        logic            call;
        logic            ret;
        logic [PC_W-1:0] target;
        logic            short_load;
        logic            long_load;
        logic            ram_load;
        logic            ram_we;
        yreg_e           dest;
        logic [1:0]      ptr;
        post_mod_e       post;
        logic [15:0]     imm;
    } ctrl_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [15:0]       pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [15:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

// File: design/dsp_fetch.sv
`timescale 1ns/10ps

module dsp_fetch import dsp_core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             run,
    input  logic             restart,
    input  logic             pm_we,
    input  logic [PM_AW-1:0] pm_addr,
    input  logic [15:0]      pm_wdata,
    input  ctrl_t            ctrl,
    input  logic             fault,
    output logic [15:0]      instr,
    output logic             instr_valid,
    output logic [PC_W-1:0]  pc,
    output logic             running
);

    logic [15:0]     pm [2**PM_AW];
    logic [PC_W-1:0] pr;          // Return address
    logic [PC_W-1:0] fetch_addr;

    assign running = run & ~fault;

    // Redirects read the target directly, so the word in flight
    // behind a jump is always its operand slot
    always_comb begin
        fetch_addr = pc;
        if (ctrl.jump || ctrl.call) begin
            fetch_addr = ctrl.target;
        end else if (ctrl.ret) begin
            fetch_addr = pr;
        end
    end

    // Host load port
    always_ff @(posedge clk) begin
        if (pm_we) begin
            pm[pm_addr] <= pm_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (running) begin
            instr <= pm[fetch_addr[PM_AW-1:0]];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc          <= '0;
            pr          <= '0;
            instr_valid <= 1'b0;
        end else if (restart) begin
            pc          <= '0;
            instr_valid <= 1'b0;
        end else if (running) begin
            pc          <= fetch_addr + 1'b1;
            instr_valid <= 1'b1;
            if (ctrl.call) begin
                pr <= pc; // Word after the operand slot
            end
        end else begin
            instr_valid <= 1'b0;
            // Word behind a fault is dropped, point back at it
            if (fault && instr_valid) begin
                pc <= pc - 1'b1;
            end
        end
    end

    a_one_redirect: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({ctrl.jump, ctrl.call, ctrl.ret})
    ) else $error("fetch: more than one redirect in ctrl");

endmodule

// File: design/dsp_decode.sv
`timescale 1ns/10ps

module dsp_decode import dsp_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        restart,
    input  logic [15:0] instr,
    input  logic        instr_valid,
    output ctrl_t       ctrl,
    output logic        fault
);

    opcode_e op;
    logic    second_word;  // Next valid word is an operand
    logic    long_pend;    // Operand is a long immediate

    assign op = opcode_e'(instr[15:11]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ctrl        <= '0;
            fault       <= 1'b0;
            second_word <= 1'b0;
            long_pend   <= 1'b0;
        end else begin
            // Strobes last one cycle
            ctrl.jump       <= 1'b0;
            ctrl.call       <= 1'b0;
            ctrl.ret        <= 1'b0;
            ctrl.short_load <= 1'b0;
            ctrl.long_load  <= 1'b0;
            ctrl.ram_load   <= 1'b0;
            ctrl.ram_we     <= 1'b0;

            if (restart) begin
                fault       <= 1'b0;
                second_word <= 1'b0;
                long_pend   <= 1'b0;
            end else if (instr_valid && !fault) begin
                if (second_word) begin
                    second_word <= 1'b0;
                    long_pend   <= 1'b0;
                    if (long_pend) begin
                        ctrl.long_load <= 1'b1;
                        ctrl.imm       <= instr; // Full 16-bit operand
                    end
                end else begin
                    case (op)
                        OP_GOTO: begin
                            ctrl.jump   <= 1'b1;
                            ctrl.target <= instr[11:0];
                            second_word <= 1'b1;
                        end
                        OP_CALL: begin
                            ctrl.call   <= 1'b1;
                            ctrl.target <= instr[11:0];
                            second_word <= 1'b1;
                        end
                        OP_RET: begin
                            ctrl.ret    <= 1'b1;
                            second_word <= 1'b1;
                        end
                        OP_SHORT_IMM: begin
                            // Bits 10:9 pick j, k, rb or re
                            ctrl.short_load <= 1'b1;
                            ctrl.dest       <= yreg_e'({1'b1, instr[10:9]});
                            ctrl.imm        <= {7'd0, instr[8:0]};
                        end
                        OP_LONG_IMM: begin
                            // Only YAAU destinations exist here
                            if (instr[9:7] == 3'b000) begin
                                ctrl.dest   <= yreg_e'(instr[6:4]);
                                long_pend   <= 1'b1;
                                second_word <= 1'b1;
                            end else begin
                                fault <= 1'b1;
                            end
                        end
                        OP_LOAD_Y, OP_STORE_Y: begin
                            ctrl.ram_load <= (op == OP_LOAD_Y);
                            ctrl.ram_we   <= (op == OP_STORE_Y);
                            ctrl.dest     <= yreg_e'(instr[6:4]);
                            ctrl.ptr      <= instr[3:2];
                            ctrl.post     <= post_mod_e'(instr[1:0]);
                            second_word   <= 1'b1;
                        end
                        default: fault <= 1'b1; // Unsupported opcode
                    endcase
                end
            end
        end
    end

    a_no_fault_on_operand: assert property (
        @(posedge clk) disable iff (rst)
        $rose(fault) |-> !$past(second_word)
    ) else $error("decode: fault raised on an operand word");

endmodule

// File: design/dsp_yaau.sv
`timescale 1ns/10ps

module dsp_yaau import dsp_core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  ctrl_t            ctrl,
    input  yreg_e            rd_sel,
    input  logic [DM_AW-1:0] dm_raddr,
    output logic [15:0]      reg_rdata,
    output logic [15:0]      dm_rdata
);

    logic [15:0]      yr [8];        // r0-r3, j, k, rb, re
    logic [15:0]      dm [2**DM_AW];
    logic [15:0]      ptr_val;
    logic [15:0]      ptr_next;
    logic [DM_AW-1:0] ram_addr;
    logic             ram_access;
    logic             wrap;

    assign ptr_val    = yr[{1'b0, ctrl.ptr}];
    assign ram_addr   = ptr_val[DM_AW-1:0]; // Pre-modify address
    assign ram_access = ctrl.ram_load | ctrl.ram_we;

    // Circular buffer only on upward steps, re of zero turns it off
    assign wrap = (ctrl.post == PM_INC || ctrl.post == PM_INC_J) &&
                  yr[RE] != 16'd0 && ptr_val == yr[RE];

    always_comb begin
        case (ctrl.post)
            PM_INC:   ptr_next = ptr_val + 16'd1;
            PM_DEC:   ptr_next = ptr_val - 16'd1;
            PM_INC_J: ptr_next = ptr_val + yr[RJ];
            default:  ptr_next = ptr_val;
        endcase
        if (wrap) begin
            ptr_next = yr[RB];
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ram_we) begin
            dm[ram_addr] <= yr[ctrl.dest];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                yr[i] <= '0;
            end
        end else begin
            if (ram_access) begin
                yr[{1'b0, ctrl.ptr}] <= ptr_next;
            end
            if (ctrl.short_load || ctrl.long_load) begin
                yr[ctrl.dest] <= ctrl.imm;
            end
            // A load into rN itself wins over the post-modify
            if (ctrl.ram_load) begin
                yr[ctrl.dest] <= dm[ram_addr];
            end
        end
    end

    // Host readback
    assign reg_rdata = yr[rd_sel];
    assign dm_rdata  = dm[dm_raddr];

    a_load_store_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(ctrl.ram_load && ctrl.ram_we)
    ) else $error("yaau: RAM load and store in one ctrl word");

endmodule

// File: design/dsp_host_apb.sv
`timescale 1ns/10ps

module dsp_host_apb import dsp_core_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  apb_req_t         apb_req,
    output apb_rsp_t         apb_rsp,
    output logic             pm_we,
    output logic [PM_AW-1:0] pm_addr,
    output logic [15:0]      pm_wdata,
    output logic             run,
    output logic             restart,
    output yreg_e            rd_sel,
    output logic [DM_AW-1:0] dm_raddr,
    input  logic [15:0]      reg_rdata,
    input  logic [15:0]      dm_rdata,
    input  logic [PC_W-1:0]  pc,
    input  logic             fault,
    input  logic             running
);

    logic              access;
    logic              wr;
    logic              aligned;
    logic              pm_hit, ctrl_hit, status_hit, reg_hit, dm_hit;
    logic [APB_AW-1:0] reg_off;

    assign access  = apb_req.psel && apb_req.penable;
    assign wr      = access && apb_req.pwrite;
    assign aligned = apb_req.paddr[1:0] == 2'b00;
    assign reg_off = apb_req.paddr - ADDR_REG_BASE;

    // Address decode, each window is 256 words wide
    assign pm_hit     = aligned && apb_req.paddr[11:10] == ADDR_PM_BASE[11:10];
    assign dm_hit     = aligned && apb_req.paddr[11:10] == ADDR_DM_BASE[11:10];
    assign reg_hit    = aligned && reg_off < 12'd32;
    assign ctrl_hit   = apb_req.paddr == ADDR_CTRL;
    assign status_hit = apb_req.paddr == ADDR_STATUS;

    assign pm_we    = wr && pm_hit && !running; // Blocked while executing
    assign pm_addr  = apb_req.paddr[PM_AW+1:2];
    assign pm_wdata = apb_req.pwdata;
    assign restart  = wr && ctrl_hit && apb_req.pwdata[0];
    assign rd_sel   = yreg_e'(reg_off[4:2]);
    assign dm_raddr = apb_req.paddr[DM_AW+1:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run <= 1'b0;
        end else if (wr && ctrl_hit) begin
            run <= apb_req.pwdata[0];
        end
    end

    always_comb begin
        apb_rsp         = '0;
        apb_rsp.pready  = 1'b1; // Zero wait states
        if (ctrl_hit)        apb_rsp.prdata = {15'd0, run};
        else if (status_hit) apb_rsp.prdata = {pc, 2'b00, fault, running};
        else if (reg_hit)    apb_rsp.prdata = reg_rdata;
        else if (dm_hit)     apb_rsp.prdata = dm_rdata;
        if (access) begin
            if (apb_req.pwrite)
                apb_rsp.pslverr = !(ctrl_hit || (pm_hit && !running));
            else
                apb_rsp.pslverr = !(ctrl_hit || status_hit || reg_hit || dm_hit);
        end
    end

    a_apb_setup_first: assert property (
        @(posedge clk) disable iff (rst)
        apb_req.penable |-> $past(apb_req.psel)
    ) else $error("apb: penable without a setup phase");

endmodule

// File: design/dsp_core_top.sv
`timescale 1ns/10ps

module dsp_core_top import dsp_core_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  apb_req_t apb_req,
    output apb_rsp_t apb_rsp
);

    // Host side
    logic             pm_we;
    logic [PM_AW-1:0] pm_addr;
    logic [15:0]      pm_wdata;
    logic             run, restart;
    yreg_e            rd_sel;
    logic [DM_AW-1:0] dm_raddr;
    logic [15:0]      reg_rdata, dm_rdata;

    // Pipeline
    logic [15:0]      instr;
    logic             instr_valid;
    logic [PC_W-1:0]  pc;
    logic             running;
    logic             fault;
    ctrl_t            ctrl;

    dsp_host_apb host_i (
        .clk, .rst, .apb_req, .apb_rsp,
        .pm_we, .pm_addr, .pm_wdata, .run, .restart,
        .rd_sel, .dm_raddr, .reg_rdata, .dm_rdata,
        .pc, .fault, .running
    );

    dsp_fetch fetch_i (
        .clk, .rst, .run, .restart, .pm_we, .pm_addr, .pm_wdata,
        .ctrl, .fault, .instr, .instr_valid, .pc, .running
    );

    dsp_decode decode_i (
        .clk, .rst, .restart, .instr, .instr_valid, .ctrl, .fault
    );

    dsp_yaau yaau_i (
        .clk, .rst, .ctrl, .rd_sel, .dm_raddr, .reg_rdata, .dm_rdata
    );

endmodule

// File: tb/dsp_core_tb.sv
`timescale 1ns/10ps

module dsp_core_tb import dsp_core_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int PAT_DEPTH  = 256;

    logic        clk;
    logic        rst;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic [15:0] pat [PAT_DEPTH];  // Pattern file image
    logic [15:0] last_rdata;
    logic        last_slverr;
    logic        last_ready;
    int          errors;
    int          checks;
    int          wd_cycles;
    integer      seed;

    dsp_core_top dsp_core_top_i (.clk, .rst, .apb_req, .apb_rsp);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // Setup, access, then one idle cycle
    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [15:0] wdata);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #(CLK_PERIOD/4);  // Mid access phase
        last_rdata  = apb_rsp.prdata;
        last_slverr = apb_rsp.pslverr;
        last_ready  = apb_rsp.pready;
        @(negedge clk);
        apb_req = '0;
        check_pready(1'b1);  // Zero wait states, so ready in every access phase
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [15:0] data);
        apb_xfer(1'b1, addr, data);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr);
        apb_xfer(1'b0, addr, 16'h0000);
    endtask

    task automatic check_reg(input yreg_e r, input logic [15:0] exp);
        apb_read(ADDR_REG_BASE + {7'd0, r, 2'b00});
        checks++;
        if (last_rdata !== exp) begin
            errors++;
            $display("error: %s got 0x%h expected 0x%h", r.name(), last_rdata, exp);
        end
    endtask

    task automatic check_dm(input logic [DM_AW-1:0] addr, input logic [15:0] exp);
        apb_read(ADDR_DM_BASE + {2'b00, addr, 2'b00});
        checks++;
        if (last_rdata !== exp) begin
            errors++;
            $display("error: dm[0x%h] got 0x%h expected 0x%h", addr, last_rdata, exp);
        end
    endtask

    task automatic check_status(input logic [PC_W-1:0] exp_pc, input logic exp_fault);
        apb_read(ADDR_STATUS);
        checks += 2;
        if (last_rdata[15:4] !== exp_pc) begin
            errors++;
            $display("error: pc got 0x%h expected 0x%h", last_rdata[15:4], exp_pc);
        end
        if (last_rdata[1] !== exp_fault) begin
            errors++;
            $display("error: fault got 0x%h expected 0x%h", last_rdata[1], exp_fault);
        end
    endtask

    task automatic check_slverr(input logic exp);
        checks++;
        if (last_slverr !== exp) begin
            errors++;
            $display("error: pslverr got 0x%h expected 0x%h", last_slverr, exp);
        end
    endtask

    task automatic check_pready(input logic exp);
        checks++;
        if (last_ready !== exp) begin
            errors++;
            $display("error: pready got 0x%h expected 0x%h", last_ready, exp);
        end
    endtask

    // Length of all records up to the end marker
    function automatic int pattern_length();
        int p;
        p = 0;
        while (p < PAT_DEPTH && pat[p] != 16'd0) begin
            p = p + 1 + int'(pat[p]);
            p = p + 1 + int'(pat[p]);
            p = p + 1 + 2 * int'(pat[p]);
        end
        return p + 1;
    endfunction

    // Load, start and check one record
    // next gets the index of the following record
    task automatic run_record(input int base, input logic load, output int next);
        int n;
        int idx;
        n = int'(pat[base]);
        for (int i = 0; load && i < n; i++) begin
            apb_write(ADDR_PM_BASE + 12'(i * 4), pat[base + 1 + i]);
            check_slverr(1'b0);
        end
        apb_write(ADDR_CTRL, 16'h0001);  // Run bit also restarts the core
        check_slverr(1'b0);
        apb_write(ADDR_PM_BASE + 12'h3FC, 16'hFFFF);  // Must bounce while busy
        check_slverr(1'b1);
        apb_read(ADDR_STATUS);
        if (last_rdata[0] !== 1'b1) begin
            errors++;
            $display("core was not running after the restart write");
        end
        apb_read(ADDR_STATUS);
        while (last_rdata[0] !== 1'b0) begin
            apb_read(ADDR_STATUS);
        end
        // Halt word is the last one, so pc stops just past it
        check_status(PC_W'(n), 1'b1);
        idx = base + 1 + n;
        for (int i = 0; i < int'(pat[idx]); i++) begin
            check_reg(yreg_e'(i), pat[idx + 1 + i]);
        end
        idx = idx + 1 + int'(pat[idx]);
        for (int i = 0; i < int'(pat[idx]); i++) begin
            check_dm(pat[idx + 1 + 2 * i][DM_AW-1:0], pat[idx + 2 + 2 * i]);
        end
        next = idx + 1 + 2 * int'(pat[idx]);
    endtask

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("timeout: the core did not halt within %0d cycles", wd_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        int                tests;
        int                rec;
        int                last_rec;
        logic [31:0]       rnd;
        logic [APB_AW-1:0] bad_addr;
        apb_req = '0;
        rst     = 1'b1;
        errors  = 0;
        checks  = 0;
        tests   = 0;
        rec     = 0;
        seed    = 32'h4de;
        $readmemh("tb/dsp_core_patterns.txt", pat);
        wd_cycles = 8 * pattern_length() + 400;  // APB transfer per word plus run time
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (rec < PAT_DEPTH && !$isunknown(pat[rec]) && pat[rec] != 16'd0) begin
            last_rec = rec;
            run_record(last_rec, 1'b1, rec);
            tests++;
        end
        if (tests == 0) begin
            errors++;
            $display("no test records found in the pattern file");
        end else begin
            run_record(last_rec, 1'b0, rec);  // Rerun after fault must match
        end

        // Unmapped, read-only and unaligned addresses
        rnd      = $random(seed);
        bad_addr = {2'b11, rnd[7:0], 2'b00};
        apb_read(bad_addr);
        check_slverr(1'b1);
        apb_write(bad_addr, 16'h5A5A);
        check_slverr(1'b1);
        apb_read(12'h408);
        check_slverr(1'b1);
        apb_write(ADDR_STATUS, 16'h0000);
        check_slverr(1'b1);
        apb_read(12'h802);
        check_slverr(1'b1);

        $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: sim.f
design/dsp_core_pkg.sv
design/dsp_fetch.sv
design/dsp_decode.sv
design/dsp_yaau.sv
design/dsp_host_apb.sv
design/dsp_core_top.sv
tb/dsp_core_tb.sv

// File: tb/dsp_core_patterns.txt
// Each test: program length, program words, register count with r0 r1 r2 r3 j k rb re,
// then the RAM pair count and address value pairs. A program length of zero ends the list
// Immediate loads
000B
10A5 133C 15F0 1677 5000 BEEF 5020 1234
5050 8001 FFFF
0008 BEEF 0000 1234 0000 00A5 8001 01F0 0077
0000
// Store then load through *rN, *rN++, *rN-- and *rN++j
0019
1600 1003 5000 0040 5030 0040 5020 C35A
6021 0000 6053 0000 6062 0000 6040 0000
781D 0000 782F 0000 785E 0000 786C 0000
FFFF
0008 0043 C35A 8001 0043 0003 01F0 0003 0000
0004 0040 C35A 0041 8001 0043 0003 0044 01F0
// Circular buffer from rb 0x10 to re 0x12
0016
1410 1612 5010 0010 5020 2222 5000 0A0A
5030 0012 6025 0000 6055 0000 6045 0000
6005 0000 602F 0000 1600 FFFF
0008 0A0A 0011 2222 0010 0003 01F0 0010 0000
0003 0010 0A0A 0011 01F0 0012 2222
// goto over two words, call and return, then goto the halt word
0014
5000 0030 0006 0000 11EE 5010 800E 0000
1202 6051 0000 0013 0000 11EE 1455 6061
0000 C000 0000 FFFF
0008 0032 0011 2222 0010 0003 0002 0055 0000
0002 0030 0055 0031 0002
0000
